//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and judge the result from the simulation log
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert \
    --top-module tb_branch_predictor -f vlog.f > build.log 2>&1 \
    && ./obj_dir/Vtb_branch_predictor > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "^test passed$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- verification/bp_patterns.txt
// Columns in hex: test op pc0 pc1 taken expected; op 0 is update, 1 is predict, 2 is idle
// An update uses pc0 as the dispatch PC; expected bit i is the prediction of slot i
1 1 00001000 00002344 0 0
1 1 00000ffc 12345678 0 0
2 0 00000100 00000000 1 0
2 0 00000100 00000000 1 0
2 2 00000000 00000000 0 0
2 1 00000100 00000108 0 2
3 0 000001f0 00000000 1 0
3 0 00000200 00000000 1 0
3 0 00000200 00000000 1 0
3 0 00000200 00000000 1 0
3 0 00000200 00000000 1 0
3 0 00000200 00000000 1 0
3 0 00000200 00000000 1 0
3 0 00000200 00000000 1 0
3 0 00000200 00000000 1 0
3 0 00000200 00000000 1 0
3 0 00000200 00000000 1 0
3 2 00000000 00000000 0 0
3 1 00000200 000001f8 0 3
3 0 00000200 00000000 0 0
3 2 00000000 00000000 0 0
3 1 000001f8 00000200 0 1
3 0 000001f8 00000000 0 0
3 2 00000000 00000000 0 0
3 1 000001f0 00000108 0 2
4 0 00000040 00000000 1 0
4 0 00000040 00000000 1 0
4 0 00000058 00000000 1 0
4 2 00000000 00000000 0 0
4 1 00000040 00000058 0 1
5 1 abc00040 7f000058 0 1
5 1 00000458 fffffc40 0 2
5 1 80000108 00000108 0 3

//--- verification/tb_branch_predictor.sv
`include "bp_consts.svh"

module tb_branch_predictor;

    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DELAY  = 2;
    localparam int RESET_CYCLES = 5;
    localparam int READY_CYCLES = 256;
    localparam int READY_LIMIT  = 300;
    localparam int PIPE_DEPTH   = 3;
    localparam int FIELDS       = 6;
    localparam int MAX_LINES    = 64;
    localparam int F_TEST       = 0;
    localparam int F_OP         = 1;
    localparam int F_PC0        = 2;
    localparam int F_PC1        = 3;
    localparam int F_TAKEN      = 4;
    localparam int F_EXP        = 5;
    localparam int OP_UPDATE    = 0;
    localparam int OP_PREDICT   = 1;

    logic                       clk;
    logic                       rst;
    bp_pkg::pc_t                pc [`BP_FETCH_WIDTH];
    logic                       update_en;
    bp_pkg::pc_t                pc_dispatch;
    logic                       taken_actual;
    logic [`BP_FETCH_WIDTH-1:0] taken_or_not;
    logic                       ready;

    logic [31:0] pat [FIELDS*MAX_LINES];
    int          num_lines   = 0;
    bit          loaded      = 1'b0;
    int          cycle       = 0;
    int          wait_cycles = 0;

    // Pending predictions, pushed by the replay and consumed in order by the checker
    int                         due_q [$];
    int                         test_q [$];
    logic [`BP_FETCH_WIDTH-1:0] exp_q [$];
    int                         rd_ptr = 0;

    int own_pass   = 0;
    int own_fail   = 0;
    int chk_pass   = 0;
    int chk_fail   = 0;
    int mark_total = 0;
    int mark_fail  = 0;

    branch_predictor i_branch_predictor (
        .clk         (clk),
        .rst         (rst),
        .pc          (pc),
        .update_en   (update_en),
        .pc_dispatch (pc_dispatch),
        .taken_actual(taken_actual),
        .taken_or_not(taken_or_not),
        .ready       (ready)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic drive_idle();
        update_en    = 1'b0;
        pc_dispatch  = '0;
        taken_actual = 1'b0;
        pc[0]        = '0;
        pc[1]        = '0;
    endtask

    task automatic load_patterns();
        for (int i = 0; i < FIELDS * MAX_LINES; i++) begin
            pat[i] = '1; // Marks words past the end of the file
        end
        $readmemh("verification/bp_patterns.txt", pat);
        while (num_lines < MAX_LINES && pat[num_lines * FIELDS + F_TEST] != '1) begin
            num_lines++;
        end
        if (num_lines == 0) begin
            $display("No pattern lines were read from verification/bp_patterns.txt");
            own_fail++;
        end
    endtask

    task automatic wait_for_ready();
        while (!ready && wait_cycles < READY_LIMIT) begin
            @(posedge clk);
            #DRIVE_DELAY;
            wait_cycles++;
        end
        if (ready && wait_cycles != READY_CYCLES) begin
            $display("Fail at time %0t: ready rose %0d cycles after reset, expected %0d",
                     $time, wait_cycles, READY_CYCLES);
            own_fail++;
        end else if (ready) begin
            own_pass++;
        end
    endtask

    task automatic apply_line(input int ln);
        int base;
        base = ln * FIELDS;
        drive_idle();
        case (pat[base + F_OP])
            OP_UPDATE: begin
                update_en    = 1'b1;
                pc_dispatch  = pat[base + F_PC0];
                taken_actual = pat[base + F_TAKEN][0];
            end
            OP_PREDICT: begin
                pc[0] = pat[base + F_PC0];
                pc[1] = pat[base + F_PC1];
                due_q.push_back(cycle + PIPE_DEPTH); // Result is registered three edges on
                test_q.push_back(pat[base + F_TEST]);
                exp_q.push_back(pat[base + F_EXP][`BP_FETCH_WIDTH-1:0]);
            end
            default: begin
                update_en = 1'b0; // Idle line
            end
        endcase
    endtask

    task automatic finish_test(input int test_no);
        int total;
        int fails;
        drive_idle();
        while (rd_ptr < due_q.size()) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
        total = own_pass + own_fail + chk_pass + chk_fail;
        fails = own_fail + chk_fail;
        $display("test %0d finished: %0d checks, %0d wrong",
                 test_no, total - mark_total, fails - mark_fail);
        mark_total = total;
        mark_fail  = fails;
    endtask

    task automatic replay_patterns();
        int cur_test;
        cur_test = pat[F_TEST];
        for (int ln = 0; ln < num_lines; ln++) begin
            if (pat[ln * FIELDS + F_TEST] != cur_test) begin
                finish_test(cur_test);
                cur_test = pat[ln * FIELDS + F_TEST];
            end
            apply_line(ln);
            @(posedge clk);
            #DRIVE_DELAY;
        end
        finish_test(cur_test);
    endtask

    task automatic check_slot(input int test_no, input int slot, input logic exp_bit,
                              input logic got_bit);
        if (got_bit !== exp_bit) begin
            $display("Fail at time %0t: test %0d slot %0d expected %0b got %0b",
                     $time, test_no, slot, exp_bit, got_bit);
            chk_fail++;
        end else begin
            chk_pass++;
        end
    endtask

    // Outputs settle after the rising edge, so the falling edge is a safe sample point
    always @(negedge clk) begin
        if (rd_ptr < due_q.size() && due_q[rd_ptr] == cycle) begin
            check_slot(test_q[rd_ptr], 0, exp_q[rd_ptr][0], taken_or_not[0]);
            check_slot(test_q[rd_ptr], 1, exp_q[rd_ptr][1], taken_or_not[1]);
            rd_ptr++;
        end
    end

    initial begin
        rst = 1'b1;
        drive_idle();
        load_patterns();
        loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;
        wait_for_ready();
        if (!ready) begin
            $display("Ready did not rise within %0d cycles after reset", READY_LIMIT);
            $display("test failed");
            $finish;
        end else begin
            if (num_lines > 0) begin
                replay_patterns();
            end
            $display("checks ok: %0d, checks wrong: %0d",
                     own_pass + chk_pass, own_fail + chk_fail);
            if (own_fail + chk_fail == 0) begin
                $display("test passed");
            end else begin
                $display("test failed");
            end
            $finish;
        end
    end

    initial begin
        wait (loaded);
        #((READY_LIMIT + 4 * num_lines) * CLK_PERIOD);
        $display("Watchdog expired before the pattern replay finished");
        $display("test failed");
        $finish;
    end

endmodule

//--- verilog/bp_consts.svh
`ifndef BP_CONSTS_SVH
`define BP_CONSTS_SVH

// Table geometry, 256 entries per table
`define BP_INDEX_BITS 8

// Local history length per branch
`define BP_HIST_BITS 8

// Number of predict slots per fetch cycle
`define BP_FETCH_WIDTH 2

// Lowest PC bit used for indexing, so the index is PC bits 9:2
`define BP_PC_LSB 2

// Values written by the post-reset sweep
`define BP_HIST_CLEAR 1
`define BP_CTR_CLEAR 2'b01

`endif

//--- verilog/bp_pkg.sv
`include "bp_consts.svh"

package bp_pkg;

    // Instruction address
    typedef logic [31:0] pc_t;

    // Index into the BHT and the PHT
    typedef logic [`BP_INDEX_BITS-1:0] tbl_index_t;

    // Newest outcome sits in bit 0
    typedef logic [`BP_HIST_BITS-1:0] hist_t;

    // Two-bit saturating counter; the top bit means taken
    typedef logic [1:0] ctr_t;

endpackage

//--- verilog/branch_predictor.sv
`include "bp_consts.svh"

module branch_predictor (
    input  logic                       clk,
    input  logic                       rst,
    input  bp_pkg::pc_t                pc [`BP_FETCH_WIDTH],
    input  logic                       update_en,
    input  bp_pkg::pc_t                pc_dispatch,
    input  logic                       taken_actual,
    output logic [`BP_FETCH_WIDTH-1:0] taken_or_not,
    output logic                       ready
);

    localparam int NUM_READ = `BP_FETCH_WIDTH + 1;
    localparam int UPD_PORT = `BP_FETCH_WIDTH; // Last read port belongs to the update path

    bp_pkg::tbl_index_t bht_raddr [NUM_READ];
    bp_pkg::hist_t      bht_rdata [NUM_READ];
    bp_pkg::tbl_index_t pht_raddr [NUM_READ];
    bp_pkg::ctr_t       pht_rdata [NUM_READ];

    bp_pkg::tbl_index_t fetch_hist_raddr [`BP_FETCH_WIDTH];
    bp_pkg::hist_t      fetch_hist_rdata [`BP_FETCH_WIDTH];
    bp_pkg::tbl_index_t fetch_ctr_raddr [`BP_FETCH_WIDTH];
    bp_pkg::ctr_t       fetch_ctr_rdata [`BP_FETCH_WIDTH];

    bp_pkg::tbl_index_t upd_hist_raddr;
    bp_pkg::tbl_index_t upd_ctr_raddr;

    logic               clearing;
    bp_pkg::tbl_index_t clear_index;
    logic               hist_we;
    bp_pkg::tbl_index_t hist_windex;
    bp_pkg::hist_t      hist_wdata;
    logic               ctr_we;
    bp_pkg::tbl_index_t ctr_windex;
    bp_pkg::ctr_t       ctr_wdata;

    for (genvar i = 0; i < `BP_FETCH_WIDTH; i++) begin : g_slot
        assign bht_raddr[i]        = fetch_hist_raddr[i];
        assign pht_raddr[i]        = fetch_ctr_raddr[i];
        assign fetch_hist_rdata[i] = bht_rdata[i];
        assign fetch_ctr_rdata[i]  = pht_rdata[i];
    end

    assign bht_raddr[UPD_PORT] = upd_hist_raddr;
    assign pht_raddr[UPD_PORT] = upd_ctr_raddr;

    pred_table #(
        .entry_t (bp_pkg::hist_t),
        .NUM_READ(NUM_READ)
    ) u_bht (
        .clk  (clk),
        .raddr(bht_raddr),
        .rdata(bht_rdata),
        .we   (hist_we),
        .waddr(hist_windex),
        .wdata(hist_wdata)
    );

    pred_table #(
        .entry_t (bp_pkg::ctr_t),
        .NUM_READ(NUM_READ)
    ) u_pht (
        .clk  (clk),
        .raddr(pht_raddr),
        .rdata(pht_rdata),
        .we   (ctr_we),
        .waddr(ctr_windex),
        .wdata(ctr_wdata)
    );

    table_clear_fsm u_table_clear_fsm (
        .clk        (clk),
        .rst        (rst),
        .clearing   (clearing),
        .clear_index(clear_index),
        .ready      (ready)
    );

    update_unit u_update_unit (
        .clk         (clk),
        .update_en   (update_en),
        .pc_dispatch (pc_dispatch),
        .taken_actual(taken_actual),
        .clearing    (clearing),
        .clear_index (clear_index),
        .hist_rdata  (bht_rdata[UPD_PORT]),
        .ctr_rdata   (pht_rdata[UPD_PORT]),
        .hist_raddr  (upd_hist_raddr),
        .ctr_raddr   (upd_ctr_raddr),
        .hist_we     (hist_we),
        .hist_windex (hist_windex),
        .hist_wdata  (hist_wdata),
        .ctr_we      (ctr_we),
        .ctr_windex  (ctr_windex),
        .ctr_wdata   (ctr_wdata)
    );

    fetch_predict_pipe u_fetch_predict_pipe (
        .clk         (clk),
        .rst         (rst),
        .ready       (ready),
        .pc          (pc),
        .hist_raddr  (fetch_hist_raddr),
        .hist_rdata  (fetch_hist_rdata),
        .ctr_raddr   (fetch_ctr_raddr),
        .ctr_rdata   (fetch_ctr_rdata),
        .taken_or_not(taken_or_not)
    );

endmodule

//--- verilog/fetch_predict_pipe.sv
`include "bp_consts.svh"

module fetch_predict_pipe (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       ready,
    input  bp_pkg::pc_t                pc [`BP_FETCH_WIDTH],
    output bp_pkg::tbl_index_t         hist_raddr [`BP_FETCH_WIDTH],
    input  bp_pkg::hist_t              hist_rdata [`BP_FETCH_WIDTH],
    output bp_pkg::tbl_index_t         ctr_raddr [`BP_FETCH_WIDTH],
    input  bp_pkg::ctr_t               ctr_rdata [`BP_FETCH_WIDTH],
    output logic [`BP_FETCH_WIDTH-1:0] taken_or_not
);

    localparam int CTR_MSB = $bits(bp_pkg::ctr_t) - 1;

    bp_pkg::hist_t               s1_hist [`BP_FETCH_WIDTH];
    bp_pkg::tbl_index_t          s1_index [`BP_FETCH_WIDTH];
    bp_pkg::ctr_t                s2_ctr [`BP_FETCH_WIDTH];
    logic [`BP_FETCH_WIDTH-1:0]  s3_taken;

    always_comb begin
        for (int i = 0; i < `BP_FETCH_WIDTH; i++) begin
            hist_raddr[i] = pc[i][`BP_PC_LSB +: `BP_INDEX_BITS];
            // PC index rides along with its own history, so both come from the same fetch
            ctr_raddr[i]  = bp_pkg::tbl_index_t'(s1_hist[i]) ^ s1_index[i];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `BP_FETCH_WIDTH; i++) begin
                s1_hist[i]  <= '0;
                s1_index[i] <= '0;
                s2_ctr[i]   <= '0;
            end
            s3_taken <= '0;
        end else begin
            for (int i = 0; i < `BP_FETCH_WIDTH; i++) begin
                s1_hist[i]  <= hist_rdata[i];
                s1_index[i] <= hist_raddr[i];
                s2_ctr[i]   <= ctr_rdata[i];
                s3_taken[i] <= ready && s2_ctr[i][CTR_MSB]; // Tables hold junk until swept
            end
        end
    end

    assign taken_or_not = s3_taken;

endmodule

//--- verilog/pred_table.sv
`include "bp_consts.svh"

module pred_table #(
    parameter type entry_t = logic,
    parameter int NUM_READ = 3
) (
    input  logic               clk,
    input  bp_pkg::tbl_index_t raddr [NUM_READ],
    output entry_t             rdata [NUM_READ],
    input  logic               we,
    input  bp_pkg::tbl_index_t waddr,
    input  entry_t             wdata
);

    localparam int DEPTH = 2 ** `BP_INDEX_BITS;

    entry_t mem [DEPTH];

    // Reads see the array as it stands, so a write lands for the next cycle's readers
    always_comb begin
        for (int r = 0; r < NUM_READ; r++) begin
            rdata[r] = mem[raddr[r]];
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

endmodule

//--- verilog/table_clear_fsm.sv
module table_clear_fsm (
    input  logic               clk,
    input  logic               rst,
    output logic               clearing,
    output bp_pkg::tbl_index_t clear_index,
    output logic               ready
);

    typedef enum logic {
        CLEAR,
        DONE
    } state_t;

    state_t             state;
    bp_pkg::tbl_index_t index;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= CLEAR;
            index <= '0;
        end else if (state == CLEAR) begin
            index <= index + 1'b1; // Wraps back to 0 as the sweep ends
            if (index == '1) begin
                state <= DONE; // Last entry is written at this same edge
            end
        end
    end

    assign clearing    = (state == CLEAR);
    assign ready       = (state == DONE);
    assign clear_index = index;

    // Once ready, the tables stay valid and no further sweep writes happen
    a_ready_sticky: assert property (
        @(posedge clk) disable iff (rst)
        ready |=> ready && !clearing
    );

endmodule

//--- verilog/update_unit.sv
`include "bp_consts.svh"

module update_unit (
    input  logic               clk,
    input  logic               update_en,
    input  bp_pkg::pc_t        pc_dispatch,
    input  logic               taken_actual,
    input  logic               clearing,
    input  bp_pkg::tbl_index_t clear_index,
    input  bp_pkg::hist_t      hist_rdata,
    input  bp_pkg::ctr_t       ctr_rdata,
    output bp_pkg::tbl_index_t hist_raddr,
    output bp_pkg::tbl_index_t ctr_raddr,
    output logic               hist_we,
    output bp_pkg::tbl_index_t hist_windex,
    output bp_pkg::hist_t      hist_wdata,
    output logic               ctr_we,
    output bp_pkg::tbl_index_t ctr_windex,
    output bp_pkg::ctr_t       ctr_wdata
);

    bp_pkg::tbl_index_t pc_index;
    bp_pkg::hist_t      hist_next;
    bp_pkg::ctr_t       ctr_next;

    assign pc_index   = pc_dispatch[`BP_PC_LSB +: `BP_INDEX_BITS];
    assign hist_raddr = pc_index;
    // Counter is picked by the history before this outcome is shifted in
    assign ctr_raddr  = bp_pkg::tbl_index_t'(hist_rdata) ^ pc_index;

    assign hist_next = {hist_rdata[`BP_HIST_BITS-2:0], taken_actual};

    always_comb begin
        ctr_next = ctr_rdata;
        if (taken_actual) begin
            if (ctr_rdata != '1) begin
                ctr_next = ctr_rdata + 1'b1;
            end
        end else if (ctr_rdata != '0) begin
            ctr_next = ctr_rdata - 1'b1;
        end
    end

    // The sweep owns both write ports until it finishes
    always_comb begin
        if (clearing) begin
            hist_we     = 1'b1;
            hist_windex = clear_index;
            hist_wdata  = bp_pkg::hist_t'(`BP_HIST_CLEAR);
            ctr_we      = 1'b1;
            ctr_windex  = clear_index;
            ctr_wdata   = bp_pkg::ctr_t'(`BP_CTR_CLEAR);
        end else begin
            hist_we     = update_en;
            hist_windex = pc_index;
            hist_wdata  = hist_next;
            ctr_we      = update_en;
            ctr_windex  = ctr_raddr;
            ctr_wdata   = ctr_next;
        end
    end

    // Dispatch must hold off until the sweep has released the tables
    a_no_update_while_clearing: assert property (
        @(posedge clk) !(update_en && clearing)
    );

endmodule

//--- vlog.f
+incdir+verilog
verilog/bp_pkg.sv
verilog/pred_table.sv
verilog/table_clear_fsm.sv
verilog/update_unit.sv
verilog/fetch_predict_pipe.sv
verilog/branch_predictor.sv
verification/tb_branch_predictor.sv
